// ==== design/matrix_input_pkg.sv ====
// ==============================
// Matrix input shared definitions
// Widths, ASCII codes, error codes and vector types
// for the serial matrix entry path
// ==============================

package matrix_input_pkg;

    // ==============================
    // Widths
    // ==============================
    localparam int ELEM_WIDTH = 8;
    localparam int ADDR_WIDTH = 10;

    // ==============================
    // Types
    // ==============================
    typedef logic [ELEM_WIDTH-1:0] elem_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    // Row or column count, also the configured limits
    typedef logic [3:0]            dim_t;
    // Element count or index, m*n is at most 225
    typedef logic [7:0]            count_t;
    typedef logic [7:0]            char_t;
    typedef logic [3:0]            err_t;

    // ==============================
    // ASCII codes
    // ==============================
    localparam char_t CHAR_SPACE = 8'h20;
    localparam char_t CHAR_CR    = 8'h0D;
    localparam char_t CHAR_LF    = 8'h0A;
    localparam char_t CHAR_ZERO  = 8'h30;

    // ==============================
    // Error codes
    // ==============================
    localparam err_t ERR_NONE        = 4'd0;
    localparam err_t ERR_DIM_RANGE   = 4'd1;
    // Also reported for an invalid character
    localparam err_t ERR_VALUE_RANGE = 4'd2;

endpackage

// ==== design/ascii_number_parser.sv ====
// ==============================
// ASCII number parser
// Turns received characters into number, end-of-line
// and bad-character tokens, one cycle after rx_done
// ==============================

`timescale 1ns/1ps

module ascii_number_parser
    import matrix_input_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  mode_active,
    input  char_t rx_data,
    input  logic  rx_done,
    input  logic  parser_clear,
    output logic  tok_num,
    output logic  tok_eol,
    output logic  tok_bad,
    output elem_t tok_value
);

    elem_t       accum;
    logic        have_digit;
    logic        is_digit;
    logic        is_eol;
    logic        is_sep;
    logic [11:0] acc_sum;
    elem_t       acc_next;

    assign is_digit = (rx_data >= CHAR_ZERO) && (rx_data <= CHAR_ZERO + char_t'(9));
    assign is_eol   = (rx_data == CHAR_CR) || (rx_data == CHAR_LF);
    assign is_sep   = is_eol || (rx_data == CHAR_SPACE);

    // accum*10 as accum*8 + accum*2, then the new digit
    assign acc_sum  = ({4'h0, accum} << 3) + ({4'h0, accum} << 1) + {8'h00, rx_data[3:0]};
    assign acc_next = (acc_sum > 12'd255) ? 8'hFF : acc_sum[7:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            accum      <= '0;
            have_digit <= 1'b0;
            tok_num    <= 1'b0;
            tok_eol    <= 1'b0;
            tok_bad    <= 1'b0;
        end else begin
            tok_num <= 1'b0;
            tok_eol <= 1'b0;
            tok_bad <= 1'b0;
            if (!mode_active || parser_clear) begin
                accum      <= '0;
                have_digit <= 1'b0;
            end else if (rx_done) begin
                if (is_digit) begin
                    accum      <= acc_next;
                    have_digit <= 1'b1;
                end else begin
                    // Separators end a number; anything else is a bad token
                    tok_num    <= is_sep && have_digit;
                    tok_eol    <= is_eol;
                    tok_bad    <= !is_sep;
                    accum      <= '0;
                    have_digit <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_done && !is_digit) begin
            tok_value <= accum;
        end
    end

endmodule

// ==== design/matrix_printer.sv ====
// ==============================
// Matrix printer
// Reads a stored matrix from RAM and sends it as rows
// of ASCII digits, each row led by CR LF
// ==============================

`timescale 1ns/1ps

module matrix_printer
    import matrix_input_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  print_start,
    input  addr_t print_base,
    input  dim_t  print_m,
    input  dim_t  print_n,
    input  logic  tx_busy,
    input  elem_t mem_rd_data,
    output char_t tx_data,
    output logic  tx_start,
    output logic  mem_rd_en,
    output addr_t mem_rd_addr,
    output logic  print_done
);

    typedef enum logic [3:0] {
        P_IDLE,
        P_CR,
        P_LF,
        P_ADDR,
        P_WAIT,
        P_LATCH,
        P_DIGIT,
        P_SEP,
        P_END_CR,
        P_END_LF
    } print_step_t;

    print_step_t step;
    dim_t        row;
    dim_t        col;
    logic [3:0]  rd_nibble;
    logic        tx_ok;

    // Transmitter free and no start issued last cycle
    assign tx_ok = !tx_busy && !tx_start;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step       <= P_IDLE;
            row        <= '0;
            col        <= '0;
            tx_start   <= 1'b0;
            mem_rd_en  <= 1'b0;
            print_done <= 1'b0;
        end else begin
            tx_start   <= 1'b0;
            print_done <= 1'b0;
            case (step)
                P_IDLE: begin
                    if (print_start) begin
                        row       <= '0;
                        col       <= '0;
                        mem_rd_en <= 1'b1;
                        step      <= P_CR;
                    end
                end
                P_CR: begin
                    if (tx_ok) begin
                        tx_start <= 1'b1;
                        step     <= P_LF;
                    end
                end
                P_LF: begin
                    if (tx_ok) begin
                        tx_start <= 1'b1;
                        step     <= P_ADDR;
                    end
                end
                P_ADDR:  step <= P_WAIT;
                // RAM answers one cycle after the address
                P_WAIT:  step <= P_LATCH;
                P_LATCH: step <= P_DIGIT;
                P_DIGIT: begin
                    if (tx_ok) begin
                        tx_start <= 1'b1;
                        step     <= P_SEP;
                    end
                end
                P_SEP: begin
                    if (col == print_n - dim_t'(1)) begin
                        col <= '0;
                        if (row == print_m - dim_t'(1)) begin
                            step <= P_END_CR;
                        end else begin
                            row  <= row + dim_t'(1);
                            step <= P_CR;
                        end
                    end else if (tx_ok) begin
                        tx_start <= 1'b1;
                        col      <= col + dim_t'(1);
                        step     <= P_ADDR;
                    end
                end
                P_END_CR: begin
                    if (tx_ok) begin
                        tx_start <= 1'b1;
                        step     <= P_END_LF;
                    end
                end
                P_END_LF: begin
                    if (tx_ok) begin
                        tx_start   <= 1'b1;
                        mem_rd_en  <= 1'b0;
                        print_done <= 1'b1;
                        step       <= P_IDLE;
                    end
                end
                default: step <= P_IDLE;
            endcase
        end
    end

    // Character, address and read data
    always_ff @(posedge clk) begin
        case (step)
            P_CR, P_END_CR: tx_data <= CHAR_CR;
            P_LF, P_END_LF: tx_data <= CHAR_LF;
            P_DIGIT:        tx_data <= CHAR_ZERO + char_t'(rd_nibble);
            P_SEP:          tx_data <= CHAR_SPACE;
            default:        tx_data <= tx_data;
        endcase
        if (step == P_ADDR) begin
            mem_rd_addr <= print_base + addr_t'(row) * addr_t'(print_n) + addr_t'(col);
        end
        if (step == P_LATCH) begin
            rd_nibble <= mem_rd_data[3:0];
        end
    end

endmodule

// ==== design/matrix_entry_ctrl.sv ====
// ==============================
// Matrix entry controller
// Dimension check, allocation, element writes, zero fill,
// commit, print start and error recovery
// ==============================

`timescale 1ns/1ps

module matrix_entry_ctrl
    import matrix_input_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  mode_active,
    input  dim_t  config_max_dim,
    input  dim_t  config_max_value,
    input  logic  rx_done,
    input  logic  tok_num,
    input  logic  tok_eol,
    input  logic  tok_bad,
    input  elem_t tok_value,
    input  dim_t  alloc_slot,
    input  addr_t alloc_addr,
    input  logic  alloc_valid,
    input  logic  print_done,
    output logic  parser_clear,
    output logic  alloc_req,
    output dim_t  alloc_m,
    output dim_t  alloc_n,
    output logic  commit_req,
    output dim_t  commit_slot,
    output dim_t  commit_m,
    output dim_t  commit_n,
    output addr_t commit_addr,
    output logic  mem_wr_en,
    output addr_t mem_wr_addr,
    output elem_t mem_wr_data,
    output logic  print_start,
    output addr_t print_base,
    output dim_t  print_m,
    output dim_t  print_n,
    output err_t  error_code,
    output logic  entry_done
);

    typedef enum logic [3:0] {
        S_IDLE, S_M, S_N, S_CHECK, S_WAIT_ALLOC, S_DATA,
        S_FILL, S_COMMIT, S_PRINT, S_DONE, S_ERROR
    } ctrl_state_t;

    ctrl_state_t state;
    count_t      total;
    count_t      idx;
    logic        allocated;
    elem_t       m_val;
    elem_t       n_val;
    dim_t        slot;
    addr_t       base_addr;
    // One token may arrive before the grant
    logic        pend_num;
    logic        pend_eol;
    logic        pend_bad;
    elem_t       pend_value;
    logic        eff_num;
    logic        eff_eol;
    logic        eff_bad;
    elem_t       eff_value;
    logic        dims_ok;
    logic        last_elem;
    logic        hold_tok;

    assign hold_tok  = (state == S_CHECK) || (state == S_WAIT_ALLOC);
    assign eff_num   = tok_num || pend_num;
    assign eff_eol   = tok_eol || pend_eol;
    assign eff_bad   = tok_bad || pend_bad;
    assign eff_value = pend_num ? pend_value : tok_value;
    assign dims_ok   = (m_val != '0) && (m_val <= elem_t'(config_max_dim)) &&
                       (n_val != '0) && (n_val <= elem_t'(config_max_dim));
    assign last_elem = (idx + count_t'(1)) == total;

    // Drop the recovering character when dimension entry restarts
    assign parser_clear = (state == S_ERROR) && rx_done && !allocated;

    assign print_start = commit_req;
    assign commit_slot = slot;
    assign commit_m    = alloc_m;
    assign commit_n    = alloc_n;
    assign commit_addr = base_addr;
    assign print_base  = base_addr;
    assign print_m     = alloc_m;
    assign print_n     = alloc_n;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            total      <= '0;
            idx        <= '0;
            allocated  <= 1'b0;
            {pend_num, pend_eol, pend_bad} <= '0;
            alloc_req  <= 1'b0;
            commit_req <= 1'b0;
            mem_wr_en  <= 1'b0;
            entry_done <= 1'b0;
            error_code <= ERR_NONE;
        end else if (!mode_active) begin
            state      <= S_IDLE;
            alloc_req  <= 1'b0;
            commit_req <= 1'b0;
            mem_wr_en  <= 1'b0;
            entry_done <= 1'b0;
            error_code <= ERR_NONE;
        end else begin
            mem_wr_en  <= 1'b0;
            commit_req <= 1'b0;
            entry_done <= 1'b0;
            if (hold_tok && (tok_num || tok_eol || tok_bad)) begin
                {pend_num, pend_eol, pend_bad} <= {tok_num, tok_eol, tok_bad};
            end
            case (state)
                S_IDLE: begin
                    idx        <= '0;
                    total      <= '0;
                    allocated  <= 1'b0;
                    {pend_num, pend_eol, pend_bad} <= '0;
                    error_code <= ERR_NONE;
                    state      <= S_M;
                end
                S_M, S_N: begin
                    if (tok_bad) begin
                        error_code <= ERR_VALUE_RANGE;
                        state      <= S_ERROR;
                    end else if (tok_num) begin
                        state <= (state == S_M) ? S_N : S_CHECK;
                    end
                end
                S_CHECK: begin
                    if (!dims_ok) begin
                        error_code <= ERR_DIM_RANGE;
                        state      <= S_ERROR;
                    end else begin
                        total     <= count_t'(m_val[3:0]) * count_t'(n_val[3:0]);
                        alloc_req <= 1'b1;
                        state     <= S_WAIT_ALLOC;
                    end
                end
                S_WAIT_ALLOC: begin
                    if (alloc_valid) begin
                        alloc_req <= 1'b0;
                        allocated <= 1'b1;
                        state     <= S_DATA;
                    end
                end
                S_DATA: begin
                    {pend_num, pend_eol, pend_bad} <= '0;
                    if (eff_bad || (eff_num && eff_value > elem_t'(config_max_value))) begin
                        error_code <= ERR_VALUE_RANGE;
                        state      <= S_ERROR;
                    end else if (eff_num) begin
                        mem_wr_en <= 1'b1;
                        idx       <= idx + count_t'(1);
                        if (last_elem) begin
                            state <= S_COMMIT;
                        end else if (eff_eol) begin
                            state <= S_FILL;
                        end
                    end else if (eff_eol) begin
                        state <= S_FILL;
                    end
                end
                S_FILL: begin
                    mem_wr_en <= 1'b1;
                    idx       <= idx + count_t'(1);
                    if (last_elem) begin
                        state <= S_COMMIT;
                    end
                end
                S_COMMIT: begin
                    commit_req <= 1'b1;
                    state      <= S_PRINT;
                end
                S_PRINT: begin
                    if (print_done) begin
                        entry_done <= 1'b1;
                        state      <= S_DONE;
                    end
                end
                S_DONE: state <= S_IDLE;
                S_ERROR: begin
                    if (rx_done) begin
                        error_code <= ERR_NONE;
                        {pend_num, pend_eol, pend_bad} <= '0;
                        state <= allocated ? S_DATA : S_M;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Dimensions, grant and write payload
    always_ff @(posedge clk) begin
        if (state == S_M && tok_num) begin
            m_val <= tok_value;
        end
        if (state == S_N && tok_num) begin
            n_val <= tok_value;
        end
        if (state == S_CHECK) begin
            alloc_m <= m_val[3:0];
            alloc_n <= n_val[3:0];
        end
        if (state == S_WAIT_ALLOC && alloc_valid) begin
            slot      <= alloc_slot;
            base_addr <= alloc_addr;
        end
        if (hold_tok && tok_num) begin
            pend_value <= tok_value;
        end
        mem_wr_addr <= base_addr + addr_t'(idx);
        mem_wr_data <= (state == S_FILL) ? '0 : eff_value;
    end

endmodule

// ==== design/matrix_input_top.sv ====
// ==============================
// Matrix input top level
// Parser, printer and entry controller on the
// serial, allocator and RAM ports
// ==============================

`timescale 1ns/1ps

module matrix_input_top
    import matrix_input_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  mode_active,
    input  dim_t  config_max_dim,
    input  dim_t  config_max_value,
    input  char_t rx_data,
    input  logic  rx_done,
    input  logic  tx_busy,
    output char_t tx_data,
    output logic  tx_start,
    output logic  alloc_req,
    output dim_t  alloc_m,
    output dim_t  alloc_n,
    input  dim_t  alloc_slot,
    input  addr_t alloc_addr,
    input  logic  alloc_valid,
    output logic  commit_req,
    output dim_t  commit_slot,
    output dim_t  commit_m,
    output dim_t  commit_n,
    output addr_t commit_addr,
    output logic  mem_wr_en,
    output addr_t mem_wr_addr,
    output elem_t mem_wr_data,
    output logic  mem_rd_en,
    output addr_t mem_rd_addr,
    input  elem_t mem_rd_data,
    output err_t  error_code,
    output logic  entry_done
);

    // Parser tokens
    logic  tok_num;
    logic  tok_eol;
    logic  tok_bad;
    elem_t tok_value;
    logic  parser_clear;

    // Printer control
    logic  print_start;
    logic  print_done;
    addr_t print_base;
    dim_t  print_m;
    dim_t  print_n;

    ascii_number_parser u_parser (
        .clk          (clk),
        .rst_n        (rst_n),
        .mode_active  (mode_active),
        .rx_data      (rx_data),
        .rx_done      (rx_done),
        .parser_clear (parser_clear),
        .tok_num      (tok_num),
        .tok_eol      (tok_eol),
        .tok_bad      (tok_bad),
        .tok_value    (tok_value)
    );

    matrix_printer u_printer (
        .clk         (clk),
        .rst_n       (rst_n),
        .print_start (print_start),
        .print_base  (print_base),
        .print_m     (print_m),
        .print_n     (print_n),
        .tx_busy     (tx_busy),
        .mem_rd_data (mem_rd_data),
        .tx_data     (tx_data),
        .tx_start    (tx_start),
        .mem_rd_en   (mem_rd_en),
        .mem_rd_addr (mem_rd_addr),
        .print_done  (print_done)
    );

    matrix_entry_ctrl u_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .mode_active      (mode_active),
        .config_max_dim   (config_max_dim),
        .config_max_value (config_max_value),
        .rx_done          (rx_done),
        .tok_num          (tok_num),
        .tok_eol          (tok_eol),
        .tok_bad          (tok_bad),
        .tok_value        (tok_value),
        .alloc_slot       (alloc_slot),
        .alloc_addr       (alloc_addr),
        .alloc_valid      (alloc_valid),
        .print_done       (print_done),
        .parser_clear     (parser_clear),
        .alloc_req        (alloc_req),
        .alloc_m          (alloc_m),
        .alloc_n          (alloc_n),
        .commit_req       (commit_req),
        .commit_slot      (commit_slot),
        .commit_m         (commit_m),
        .commit_n         (commit_n),
        .commit_addr      (commit_addr),
        .mem_wr_en        (mem_wr_en),
        .mem_wr_addr      (mem_wr_addr),
        .mem_wr_data      (mem_wr_data),
        .print_start      (print_start),
        .print_base       (print_base),
        .print_m          (print_m),
        .print_n          (print_n),
        .error_code       (error_code),
        .entry_done       (entry_done)
    );

endmodule

// ==== sim/matrix_input_tests.svh ====
// ==============================
// Matrix input tests
// Stimulus tasks, reference function and the six tests
// ==============================

task automatic compare_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    checks++;
    assert (got === want) else begin
        $display("ERROR %s: got %h expected %h", name, got, want);
        errors++;
    end
endtask

function automatic int rand_below(input int limit);
    return ($random(seed) & 32'h7FFF_FFFF) % limit;
endfunction

// One character, then two idle cycles
task automatic send_char(input byte c);
    rx_data = char_t'(c);
    rx_done = 1'b1;
    @(negedge clk);
    rx_done = 1'b0;
    repeat (2) @(negedge clk);
endtask

task automatic send_text(input string s);
    for (int i = 0; i < s.len(); i++) begin
        send_char(s[i]);
    end
endtask

// Expected elements with zero fill, and the echoed text
function automatic string model_entry(input string typed, input int max_dim,
                                      input int max_val, input int base);
    int    acc = 0;
    bit    have = 0;
    int    dims [2];
    int    nd = 0;
    bit    granted = 0;
    bit    drop_next = 0;
    bit    complete = 0;
    bit    is_eol;
    int    idx = 0;
    int    total = 0;
    char_t c;
    string txt;
    exp_base = base;
    for (int i = 0; i < typed.len(); i++) begin
        c      = typed[i];
        is_eol = (c == CHAR_CR) || (c == CHAR_LF);
        if (drop_next || complete) begin
            // Character that clears a dimension error is lost
            drop_next = 0;
        end else if (c >= CHAR_ZERO && c <= CHAR_ZERO + 8'd9) begin
            acc  = acc * 10 + (int'(c) - int'(CHAR_ZERO));
            acc  = (acc > 255) ? 255 : acc;
            have = 1;
        end else if (c == CHAR_SPACE || is_eol) begin
            if (!granted) begin
                if (have) begin
                    dims[nd] = acc;
                    nd++;
                end
                if (nd == 2) begin
                    nd = 0;
                    if (dims[0] < 1 || dims[0] > max_dim || dims[1] < 1 || dims[1] > max_dim) begin
                        drop_next = 1;
                    end else begin
                        granted = 1;
                        total   = dims[0] * dims[1];
                    end
                end
            end else if (!(have && acc > max_val)) begin
                if (have) begin
                    exp_vals[idx] = elem_t'(acc);
                    idx++;
                end
                if (idx < total && is_eol) begin
                    while (idx < total) begin
                        exp_vals[idx] = '0;
                        idx++;
                    end
                end
                complete = (idx == total);
            end
            acc  = 0;
            have = 0;
        end else begin
            acc       = 0;
            have      = 0;
            drop_next = !granted;
            nd        = granted ? nd : 0;
        end
    end
    exp_m     = dims[0];
    exp_n     = dims[1];
    exp_count = idx;
    txt       = "";
    for (int r = 0; r < exp_m; r++) begin
        txt = {txt, "\r\n"};
        for (int k = 0; k < exp_n; k++) begin
            txt = $sformatf("%s%c", txt, CHAR_ZERO + char_t'(exp_vals[r * exp_n + k][3:0]));
            if (k < exp_n - 1)
                txt = {txt, " "};
        end
    end
    return {txt, "\r\n"};
endfunction

task automatic compare_text();
    int limit;
    limit = (tx_log.len() < exp_text.len()) ? tx_log.len() : exp_text.len();
    checks++;
    assert (tx_log.len() == exp_text.len()) else begin
        $display("printed text has %0d characters, %0d expected", tx_log.len(), exp_text.len());
        errors++;
    end
    for (int i = 0; i < limit; i++) begin
        if (tx_log[i] != exp_text[i]) begin
            compare_value($sformatf("tx_data char %0d", i), tx_log[i], exp_text[i]);
            break;
        end
    end
endtask

// Types one entry, waits for entry_done and checks the result
task automatic run_matrix(input string typed, input int base);
    exp_text      = model_entry(typed, MAX_DIM, MAX_VALUE, base);
    grant_addr    = addr_t'(base);
    wr_count      = 0;
    commit_count  = 0;
    alloc_count   = 0;
    dim_err_count = 0;
    val_err_count = 0;
    done_count    = 0;
    tx_log        = "";
    send_text(typed);
    while (done_count == 0)
        @(negedge clk);
    compare_value("mem_wr_en count", wr_count, exp_count);
    compare_value("commit_req count", commit_count, 1);
    for (int i = 0; i < exp_count; i++) begin
        compare_value($sformatf("ram[%0d]", base + i), ram[base + i], exp_vals[i]);
    end
    compare_text();
    // Back at dimension entry before the next matrix
    repeat (3) @(negedge clk);
endtask

task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before)
        $display("test %0d %s: ok", tests_run, name);
    else
        $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
endtask

// ==============================
// Tests
// ==============================
task automatic basic_entry();
    int e0;
    e0 = errors;
    run_matrix("2 3 1 2 3 4 5 6 ", 40);
    compare_value("alloc_req rises", alloc_count, 1);
    report_test("2x3 entry", e0);
endtask

task automatic early_enter();
    int e0;
    e0 = errors;
    run_matrix("2 2 7\r", 40);
    report_test("early enter zero fill", e0);
endtask

task automatic dim_errors();
    int e0;
    e0 = errors;
    run_matrix("5 2  0 1  1 2 3 4 ", 40);
    compare_value("error_code DIM_RANGE events", dim_err_count, 2);
    compare_value("alloc_req rises", alloc_count, 1);
    compare_value("error_code", error_code, ERR_NONE);
    report_test("dimension range errors", e0);
endtask

task automatic value_error();
    int e0;
    e0 = errors;
    run_matrix("2 2 1 12 2 3 4 ", 40);
    compare_value("error_code VALUE_RANGE events", val_err_count, 1);
    compare_value("error_code", error_code, ERR_NONE);
    report_test("value above maximum", e0);
endtask

// Values differ from the previous matrix at every address
task automatic bad_char();
    int e0;
    e0 = errors;
    run_matrix("2 2 4 x 3 2 1 ", 40);
    compare_value("error_code VALUE_RANGE events", val_err_count, 1);
    report_test("invalid character", e0);
endtask

task automatic random_matrices();
    int    e0;
    int    m;
    int    n;
    string typed;
    e0 = errors;
    for (int t = 0; t < 10; t++) begin
        m     = rand_below(4) + 1;
        n     = rand_below(4) + 1;
        typed = (rand_below(3) == 0) ? $sformatf("%0d  %0d ", m, n) : $sformatf("%0d %0d ", m, n);
        for (int k = 0; k < m * n; k++) begin
            typed = $sformatf("%s%0d", typed, rand_below(10));
            if (k < m * n - 1 && rand_below(8) == 0) begin
                typed = {typed, "\r"};
                break;
            end
            typed = {typed, " "};
            if (k < m * n - 1 && rand_below(4) == 0)
                typed = {typed, " "};
        end
        run_matrix(typed, rand_below(1000));
    end
    report_test("ten random matrices", e0);
endtask

// ==== sim/matrix_input_tb.sv ====
// ==============================
// Matrix input testbench
// Clock, reset, DUT, RAM, allocator and transmitter
// models, write and commit checker, watchdog
// ==============================

`timescale 1ns/1ps

module matrix_input_tb
    import matrix_input_pkg::*;
();

    localparam int   CLK_PERIOD      = 100;
    localparam int   WATCHDOG_CYCLES = 6 * 400 * 10;
    localparam dim_t MAX_DIM         = 4'd4;
    localparam dim_t MAX_VALUE       = 4'd9;
    localparam dim_t GRANT_SLOT      = 4'd3;
    localparam int   GRANT_DELAY     = 4;

    // DUT ports
    logic  clk;
    logic  rst_n;
    logic  mode_active;
    dim_t  config_max_dim;
    dim_t  config_max_value;
    char_t rx_data;
    logic  rx_done;
    logic  tx_busy;
    char_t tx_data;
    logic  tx_start;
    logic  alloc_req;
    dim_t  alloc_m;
    dim_t  alloc_n;
    dim_t  alloc_slot;
    addr_t alloc_addr;
    logic  alloc_valid;
    logic  commit_req;
    dim_t  commit_slot;
    dim_t  commit_m;
    dim_t  commit_n;
    addr_t commit_addr;
    logic  mem_wr_en;
    addr_t mem_wr_addr;
    elem_t mem_wr_data;
    logic  mem_rd_en;
    addr_t mem_rd_addr;
    elem_t mem_rd_data;
    err_t  error_code;
    logic  entry_done;

    elem_t ram [0:(1 << ADDR_WIDTH) - 1];
    int    seed;
    int    errors;
    int    checks;
    int    tests_run;

    // Expected results from the reference function
    elem_t exp_vals [0:255];
    int    exp_count;
    int    exp_m;
    int    exp_n;
    int    exp_base;
    string exp_text;

    // Observed activity for the current matrix
    int    wr_count;
    int    commit_count;
    int    alloc_count;
    int    dim_err_count;
    int    val_err_count;
    int    done_count;
    string tx_log;
    int    busy_left;
    int    grant_wait;
    addr_t grant_addr;
    logic  alloc_req_q;
    err_t  error_q;

    `include "matrix_input_tests.svh"

    matrix_input_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==============================
    // Models
    // ==============================
    always @(negedge clk) begin
        if (mem_wr_en === 1'b1)
            ram[mem_wr_addr] = mem_wr_data;
        if (mem_rd_en === 1'b1)
            mem_rd_data = ram[mem_rd_addr];
    end

    // Grant a few cycles after the request rises
    always @(negedge clk) begin
        if (alloc_req !== 1'b1) begin
            grant_wait  = 0;
            alloc_valid = 1'b0;
        end else if (alloc_valid) begin
            alloc_valid = 1'b0;
        end else begin
            grant_wait++;
            if (grant_wait == GRANT_DELAY) begin
                alloc_slot  = GRANT_SLOT;
                alloc_addr  = grant_addr;
                alloc_valid = 1'b1;
            end
        end
    end

    // Busy for two cycles after each character
    always @(negedge clk) begin
        if (tx_start === 1'b1) begin
            tx_log    = $sformatf("%s%c", tx_log, tx_data);
            tx_busy   = 1'b1;
            busy_left = 2;
        end else if (busy_left > 0) begin
            busy_left--;
            tx_busy = (busy_left > 0);
        end
    end

    // ==============================
    // Write and commit checker
    // ==============================
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (mem_wr_en) begin
                checks++;
                assert (wr_count < exp_count) else begin
                    $display("unexpected write: %0d elements were expected", exp_count);
                    errors++;
                end
                if (wr_count < exp_count) begin
                    compare_value("mem_wr_addr", mem_wr_addr, exp_base + wr_count);
                    compare_value("mem_wr_data", mem_wr_data, exp_vals[wr_count]);
                end
                wr_count++;
            end
            if (commit_req) begin
                commit_count++;
                compare_value("commit_slot", commit_slot, GRANT_SLOT);
                compare_value("commit_m", commit_m, exp_m);
                compare_value("commit_n", commit_n, exp_n);
                compare_value("commit_addr", commit_addr, exp_base);
                compare_value("mem_wr_en count at commit_req", wr_count, exp_count);
            end
            if (alloc_req && !alloc_req_q) begin
                alloc_count++;
                compare_value("alloc_m", alloc_m, exp_m);
                compare_value("alloc_n", alloc_n, exp_n);
            end
            if (error_code != error_q) begin
                if (error_code == ERR_DIM_RANGE)
                    dim_err_count++;
                if (error_code == ERR_VALUE_RANGE)
                    val_err_count++;
            end
            if (entry_done)
                done_count++;
            alloc_req_q = alloc_req;
            error_q     = error_code;
        end
    end

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        seed             = 15;
        errors           = 0;
        checks           = 0;
        tests_run        = 0;
        exp_count        = 0;
        wr_count         = 0;
        busy_left        = 0;
        grant_wait       = 0;
        grant_addr       = '0;
        alloc_req_q      = 1'b0;
        error_q          = ERR_NONE;
        tx_log           = "";
        rst_n            = 1'b0;
        mode_active      = 1'b0;
        config_max_dim   = MAX_DIM;
        config_max_value = MAX_VALUE;
        rx_data          = '0;
        rx_done          = 1'b0;
        tx_busy          = 1'b0;
        alloc_slot       = '0;
        alloc_addr       = '0;
        alloc_valid      = 1'b0;
        mem_rd_data      = '0;
        // Two rising edges in reset, release on the falling edge
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n       = 1'b1;
        mode_active = 1'b1;
        repeat (2) @(negedge clk);
        basic_entry();
        early_enter();
        dim_errors();
        value_error();
        bad_char();
        random_matrices();
        $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== matrix_input_top.f ====
+incdir+sim
design/matrix_input_pkg.sv
design/ascii_number_parser.sv
design/matrix_printer.sv
design/matrix_entry_ctrl.sv
design/matrix_input_top.sv
sim/matrix_input_tb.sv

// ==== Bender.yml ====
package:
  name: matrix_input

sources:
  - target: any(rtl, synthesis, simulation)
    files:
      - design/matrix_input_pkg.sv
      - design/ascii_number_parser.sv
      - design/matrix_printer.sv
      - design/matrix_entry_ctrl.sv
      - design/matrix_input_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/matrix_input_tb.sv
